//--- sim.f
i2s_bus_pkg.sv
i2s_audio_pkg.sv
frame_if.sv
i2s_reg_frontend.sv
i2s_frame_fifo.sv
i2s_serializer.sv
i2s_bus_top.sv
i2s_bus_asserts.sv
tb_i2s_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the I2S audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_i2s_bus -f sim.f -Mdir obj_dir -o tb_i2s_bus
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_i2s_bus
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit $status

//--- tb_i2s_bus.sv
`timescale 1ns/10ps

module tb_i2s_bus import i2s_bus_pkg::*, i2s_audio_pkg::*; ();

    localparam int TIMEOUT = 20000;

    logic                 audio_clk;
    logic                 rst_n;
    logic                 av_sel;
    logic [AV_ADDR_W-1:0] av_addr;
    logic [AV_BE_W-1:0]   av_be;
    logic                 av_read;
    logic                 av_write;
    logic [AV_DATA_W-1:0] av_wdata;
    logic [AV_DATA_W-1:0] av_rdata;
    logic                 av_wait;
    logic                 sdin;
    logic                 sclk;
    logic                 lrck;
    logic                 mclk;

    int           cyc = 0;
    logic [31:0]  lfsr;
    string        test_name = "reset";
    frame_u       exp_q [$];
    int           done_q [$];
    int           bnd_q [$];
    frame_u       rx_q [$];
    int           next_exp = 0;
    int           rx_count = 0;
    logic [FRAME_W-1:0] rx_sr = '0;
    frame_u       rx_f;
    logic         prev_lrck = 1'b0;
    logic         prev_sclk = 1'b0;
    logic         prev_mclk = 1'b0;
    logic         mclk_live = 1'b0;
    logic         rx_lrck = 1'b0;
    logic         rx_synced = 1'b0;
    int           half_bits = 0;

    i2s_bus_top i2s_bus_top_inst (
        .i_Audio_Clk       (audio_clk),
        .i_rst_n           (rst_n),
        .i_av_slave_sel    (av_sel),
        .i_av_reg_addr     (av_addr),
        .i_av_byte_en      (av_be),
        .i_av_read         (av_read),
        .i_av_write        (av_write),
        .i_av_write_data   (av_wdata),
        .o_av_read_data    (av_rdata),
        .o_av_wait_request (av_wait),
        .o_i2s_sdin        (sdin),
        .o_i2s_sclk        (sclk),
        .o_i2s_lrck        (lrck),
        .o_i2s_mclk        (mclk)
    );

    initial begin
        audio_clk = 1'b0;
        forever #10 audio_clk = ~audio_clk;
    end

    always @(posedge audio_clk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_frame(input string what, input frame_u want, input frame_u got);
        if (got.raw !== want.raw) begin
            abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                test_name, what, want.raw, got.raw));
        end
    endtask

    task automatic check_word(input string what, input logic [AV_DATA_W-1:0] want,
                              input logic [AV_DATA_W-1:0] got);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                test_name, what, want, got));
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic frame_u rand_frame();
        frame_u f;
        for (int i = 0; i < FRAME_W; i++) begin
            f.raw[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return f;
    endfunction

    // Register value after a byte-enabled write, upper lane unused
    function automatic logic [AV_DATA_W-1:0] merge_lanes(input logic [AV_DATA_W-1:0] old_v,
        input logic [AV_DATA_W-1:0] new_v, input logic [AV_BE_W-1:0] be);
        logic [AV_DATA_W-1:0] r;
        r = old_v;
        for (int k = 0; k < SAMPLE_BYTES; k++) begin
            if (be[k]) begin
                r[8*k +: 8] = new_v[8*k +: 8];
            end
        end
        return r;
    endfunction

    // Frame fetched at boundary b, silence if nothing was stored by then
    function automatic frame_u predict_frame(input int b);
        frame_u f;
        f.raw = '0;
        if (next_exp < exp_q.size() && done_q[next_exp] <= b + 1) begin
            f = exp_q[next_exp];
            next_exp++;
        end
        return f;
    endfunction

    task automatic bus_write(input logic [AV_ADDR_W-1:0] addr, input logic [AV_DATA_W-1:0] data,
                             input logic [AV_BE_W-1:0] be, output int held, output int done_at);
        int n;
        n = 0;
        av_sel   = 1'b1;
        av_addr  = addr;
        av_be    = be;
        av_wdata = data;
        av_write = 1'b1;
        @(posedge audio_clk);
        #2;
        while (av_wait) begin
            if (n > TIMEOUT) begin
                abort_run("Wait request never dropped after a register write");
            end
            @(posedge audio_clk);
            #2;
            n++;
        end
        held     = n;
        done_at  = cyc;
        av_write = 1'b0;
        av_sel   = 1'b0;
        // Ack still draining
        @(posedge audio_clk);
        #2;
    endtask

    task automatic av_read_check(input string what, input logic [AV_ADDR_W-1:0] addr,
                                 input logic [AV_DATA_W-1:0] want);
        av_sel  = 1'b1;
        av_addr = addr;
        av_read = 1'b1;
        @(posedge audio_clk);
        #2;
        av_sel  = 1'b0;
        av_read = 1'b0;
        check_word(what, want, av_rdata);
    endtask

    task automatic push_frame(input frame_u f, output int held);
        int w;
        bus_write(REG_DATAL, AV_DATA_W'(f.stereo.left), 4'b0111, held, w);
        bus_write(REG_DATAR, AV_DATA_W'(f.stereo.right), 4'b0111, held, w);
        exp_q.push_back(f);
        done_q.push_back(w);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (next_exp < exp_q.size()) begin
            if (n > TIMEOUT) begin
                abort_run("Written frames did not all appear on SDIN");
            end
            @(posedge audio_clk);
            #2;
            n++;
        end
    endtask

    task automatic wait_frames(input int cnt);
        int n;
        int target;
        n = 0;
        target = rx_count + cnt;
        while (rx_count < target) begin
            if (n > TIMEOUT) begin
                abort_run("No I2S frames received");
            end
            @(posedge audio_clk);
            #2;
            n++;
        end
    endtask

    // I2S receiver and frame boundary monitor
    always @(negedge audio_clk) begin
        if (rst_n) begin
            // MCLK runs at half the audio clock
            if (mclk_live && mclk == prev_mclk) begin
                abort_run("MCLK did not toggle on an audio clock cycle");
            end
            mclk_live = 1'b1;
            if (prev_lrck && !lrck) begin
                bnd_q.push_back(cyc);
            end
            if (sclk && !prev_sclk) begin
                rx_sr = {rx_sr[FRAME_W-2:0], sdin};
                if (lrck != rx_lrck) begin
                    if (rx_synced && half_bits != SAMPLE_W) begin
                        abort_run("LRCK half period is not one sample long");
                    end
                    rx_synced = 1'b1;
                    half_bits = 1;
                    // LSB of right lands after LRCK falls
                    if (!lrck) begin
                        rx_f.stereo.left  = rx_sr[FRAME_W-1 -: SAMPLE_W];
                        rx_f.stereo.right = rx_sr[SAMPLE_W-1:0];
                        rx_q.push_back(rx_f);
                    end
                end else begin
                    half_bits++;
                end
                rx_lrck = lrck;
            end
        end
        prev_lrck = lrck;
        prev_sclk = sclk;
        prev_mclk = mclk;
    end

    initial begin : compare_frames
        frame_u got;
        frame_u want;
        forever begin
            @(posedge audio_clk);
            if (rx_q.size() > rx_count) begin
                got = rx_q[rx_count];
                rx_count++;
                // Two silent frames fill the serializer after reset
                if (rx_count <= 2) begin
                    want.raw = '0;
                end else begin
                    want = predict_frame(bnd_q[rx_count - 3]);
                end
                check_frame($sformatf("frame %0d", rx_count), want, got);
            end
        end
    end

    initial begin : main_seq
        int held;
        logic [AV_DATA_W-1:0] left_m;
        logic [AV_DATA_W-1:0] right_m;
        int w;
        rst_n    = 1'b0;
        av_sel   = 1'b0;
        av_addr  = '0;
        av_be    = '0;
        av_read  = 1'b0;
        av_write = 1'b0;
        av_wdata = '0;
        lfsr     = 32'hf47e;
        left_m   = '0;
        right_m  = '0;
        repeat (3) @(posedge audio_clk);
        #2;
        rst_n = 1'b1;

        check_word("wait request", '0, AV_DATA_W'(av_wait));
        check_word("read data", '0, av_rdata);
        av_read_check("CNTRL", REG_CNTRL, '0);

        test_name = "readback";
        bus_write(REG_DATAL, 32'hdea1b2c3, 4'b1111, held, w);
        left_m = merge_lanes(left_m, 32'hdea1b2c3, 4'b1111);
        bus_write(REG_DATAL, 32'h00556600, 4'b0010, held, w);
        left_m = merge_lanes(left_m, 32'h00556600, 4'b0010);
        av_read_check("DATAL", REG_DATAL, left_m);
        bus_write(REG_DATAR, 32'h00123456, 4'b0011, held, w);
        right_m = merge_lanes(right_m, 32'h00123456, 4'b0011);
        bus_write(REG_DATAR, 32'hff00ff00, 4'b1010, held, w);
        right_m = merge_lanes(right_m, 32'hff00ff00, 4'b1010);
        if (held != 0) begin
            abort_run("DATAR write without lane 2 started a push");
        end
        av_read_check("DATAR", REG_DATAR, right_m);

        test_name = "stream";
        repeat (6) push_frame(rand_frame(), held);
        wait_drained();

        test_name = "underrun";
        wait_frames(3);
        push_frame(rand_frame(), held);
        wait_drained();

        test_name = "backpressure";
        repeat (FIFO_DEPTH + 2) push_frame(rand_frame(), held);
        av_read_check("CNTRL full", REG_CNTRL, AV_DATA_W'(1));
        push_frame(rand_frame(), held);
        if (held <= 4) begin
            abort_run("DATAR push was not held off while the FIFO was full");
        end
        wait_drained();
        wait_frames(2);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- i2s_bus_asserts.sv
`timescale 1ns/10ps

module i2s_bus_asserts (
    input logic i_Audio_Clk,
    input logic i_rst_n,
    input logic i_wr_req,
    input logic i_wr_ack,
    input logic i_wr_full,
    input logic i_rd_req,
    input logic i_rd_ack
);

    // Ack only answers a live request
    wr_ack_with_req: assert property (@(posedge i_Audio_Clk) disable iff (!i_rst_n)
        $rose(i_wr_ack) |-> i_wr_req)
        else $error("Write ack rose without a write request");

    rd_ack_with_req: assert property (@(posedge i_Audio_Clk) disable iff (!i_rst_n)
        $rose(i_rd_ack) |-> i_rd_req)
        else $error("Read ack rose without a read request");

    // Request stays up until answered
    wr_req_held: assert property (@(posedge i_Audio_Clk) disable iff (!i_rst_n)
        i_wr_req && !i_wr_ack |=> i_wr_req)
        else $error("Write request dropped before its ack");

    rd_req_held: assert property (@(posedge i_Audio_Clk) disable iff (!i_rst_n)
        i_rd_req && !i_rd_ack |=> i_rd_req)
        else $error("Read request dropped before its ack");

    wr_ack_not_full: assert property (@(posedge i_Audio_Clk) disable iff (!i_rst_n)
        $rose(i_wr_ack) |-> !$past(i_wr_full))
        else $error("Write ack rose while the FIFO was full");

endmodule

bind i2s_frame_fifo i2s_bus_asserts fifo_asserts_inst (
    .i_Audio_Clk (i_Audio_Clk),
    .i_rst_n     (i_rst_n),
    .i_wr_req    (wr.req),
    .i_wr_ack    (wr.ack),
    .i_wr_full   (fifo_full),
    .i_rd_req    (rd.req),
    .i_rd_ack    (rd.ack)
);

//--- i2s_bus_top.sv
`timescale 1ns/10ps

module i2s_bus_top import i2s_bus_pkg::*; (
    input  logic                 i_Audio_Clk,
    input  logic                 i_rst_n,

    input  logic                 i_av_slave_sel,
    input  logic [AV_ADDR_W-1:0] i_av_reg_addr,
    input  logic [AV_BE_W-1:0]   i_av_byte_en,
    input  logic                 i_av_read,
    input  logic                 i_av_write,
    input  logic [AV_DATA_W-1:0] i_av_write_data,
    output logic [AV_DATA_W-1:0] o_av_read_data,
    output logic                 o_av_wait_request,

    output logic                 o_i2s_sdin,
    output logic                 o_i2s_sclk,
    output logic                 o_i2s_lrck,
    output logic                 o_i2s_mclk
);

    frame_wr_if wr_if ();
    frame_rd_if rd_if ();

    i2s_reg_frontend frontend_inst (
        .i_Audio_Clk       (i_Audio_Clk),
        .i_rst_n           (i_rst_n),
        .i_av_slave_sel    (i_av_slave_sel),
        .i_av_reg_addr     (i_av_reg_addr),
        .i_av_byte_en      (i_av_byte_en),
        .i_av_read         (i_av_read),
        .i_av_write        (i_av_write),
        .i_av_write_data   (i_av_write_data),
        .o_av_read_data    (o_av_read_data),
        .o_av_wait_request (o_av_wait_request),
        .wr                (wr_if.producer)
    );

    i2s_frame_fifo fifo_inst (
        .i_Audio_Clk (i_Audio_Clk),
        .i_rst_n     (i_rst_n),
        .wr          (wr_if.buffer),
        .rd          (rd_if.buffer)
    );

    i2s_serializer serializer_inst (
        .i_Audio_Clk (i_Audio_Clk),
        .i_rst_n     (i_rst_n),
        .rd          (rd_if.consumer),
        .o_sdin      (o_i2s_sdin),
        .o_sclk      (o_i2s_sclk),
        .o_lrck      (o_i2s_lrck),
        .o_mclk      (o_i2s_mclk)
    );

endmodule

//--- i2s_serializer.sv
`timescale 1ns/10ps

module i2s_serializer import i2s_audio_pkg::*; (
    input  logic         i_Audio_Clk,
    input  logic         i_rst_n,
    frame_rd_if.consumer rd,
    output logic         o_sdin,
    output logic         o_sclk,
    output logic         o_lrck,
    output logic         o_mclk
);

    logic [DIV_CNT_W-1:0] div_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BIT_CNT_W-1:0] bit_nxt;
    logic [FRAME_W-1:0]   shift_q;
    frame_u               next_frame;
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic                 frame_start;

    assign sclk_rise = (div_cnt == DIV_CNT_W'(SCLK_HALF - 1));
    assign sclk_fall = (div_cnt == DIV_CNT_W'(SCLK_DIV - 1));

    // Bit position inside the 48 bit frame
    assign bit_nxt     = (bit_cnt == BIT_CNT_W'(FRAME_W - 1)) ? '0 : bit_cnt + 1'b1;
    assign frame_start = sclk_fall && (bit_nxt == '0);

    // MCLK and SCLK generation
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_sclk  <= 1'b0;
            o_mclk  <= 1'b0;
        end else begin
            div_cnt <= sclk_fall ? '0 : div_cnt + 1'b1;
            if ((int'(div_cnt) % MCLK_HALF) == (MCLK_HALF - 1)) begin
                o_mclk <= ~o_mclk;
            end
            if (sclk_rise) begin
                o_sclk <= 1'b1;
            end else if (sclk_fall) begin
                o_sclk <= 1'b0;
            end
        end
    end

    // Data and LRCK move on SCLK falling edges
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
            shift_q <= '0;
            o_sdin  <= 1'b0;
            o_lrck  <= 1'b0;
        end else if (sclk_fall) begin
            bit_cnt <= bit_nxt;
            o_lrck  <= (bit_nxt >= BIT_CNT_W'(SAMPLE_W));
            o_sdin  <= shift_q[FRAME_W-1];
            // Last right bit goes out while the new frame loads
            if (frame_start) begin
                shift_q <= {next_frame.stereo.left, next_frame.stereo.right};
            end else begin
                shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
            end
        end
    end

    // Fetch the frame for the following period
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            rd.req     <= 1'b0;
            next_frame <= '0;
        end else begin
            if (frame_start && !rd.req && !rd.ack) begin
                rd.req <= 1'b1;
            end else if (rd.req && rd.ack) begin
                rd.req <= 1'b0;
                // Silent frame on underrun
                next_frame.raw <= rd.underrun ? '0 : rd.frame.raw;
            end
        end
    end

endmodule

//--- i2s_frame_fifo.sv
`timescale 1ns/10ps

module i2s_frame_fifo import i2s_audio_pkg::*; (
    input  logic       i_Audio_Clk,
    input  logic       i_rst_n,
    frame_wr_if.buffer wr,
    frame_rd_if.buffer rd
);

    logic [FRAME_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               wr_req_q;
    logic               rd_req_q;
    logic               wr_pend;
    logic               wr_rise;
    logic               rd_rise;
    logic               fifo_full;
    logic               fifo_empty;
    logic               push;
    logic               pop;

    // One entry per req rising edge
    assign wr_rise    = wr.req && !wr_req_q;
    assign rd_rise    = rd.req && !rd_req_q;
    assign fifo_full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);

    // A push held off by full waits in wr_pend
    assign push = (wr_rise || wr_pend) && wr.req && !fifo_full;
    assign pop  = rd_rise && !fifo_empty;

    always_ff @(posedge i_Audio_Clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.frame.raw;
        end
    end

    // Head entry, or silence when empty
    always_ff @(posedge i_Audio_Clk) begin
        if (rd_rise) begin
            rd.frame.raw <= fifo_empty ? '0 : mem[rd_ptr];
        end
    end

    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            wr_req_q    <= 1'b0;
            rd_req_q    <= 1'b0;
            wr_pend     <= 1'b0;
            wr.ack      <= 1'b0;
            wr.full     <= 1'b0;
            rd.ack      <= 1'b0;
            rd.underrun <= 1'b0;
        end else begin
            wr_req_q <= wr.req;
            rd_req_q <= rd.req;
            wr.full  <= fifo_full;

            if (push) begin
                wr_ptr  <= wr_ptr + 1'b1;
                wr.ack  <= 1'b1;
                wr_pend <= 1'b0;
            end else if (wr_rise) begin
                wr_pend <= 1'b1;
            end
            if (!wr.req) begin
                wr.ack <= 1'b0;
            end

            if (rd_rise) begin
                rd.ack      <= 1'b1;
                rd.underrun <= fifo_empty;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (!rd.req) begin
                rd.ack <= 1'b0;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- i2s_reg_frontend.sv
`timescale 1ns/10ps

module i2s_reg_frontend import i2s_bus_pkg::*, i2s_audio_pkg::*; (
    input  logic                 i_Audio_Clk,
    input  logic                 i_rst_n,

    input  logic                 i_av_slave_sel,
    input  logic [AV_ADDR_W-1:0] i_av_reg_addr,
    input  logic [AV_BE_W-1:0]   i_av_byte_en,
    input  logic                 i_av_read,
    input  logic                 i_av_write,
    input  logic [AV_DATA_W-1:0] i_av_write_data,
    output logic [AV_DATA_W-1:0] o_av_read_data,
    output logic                 o_av_wait_request,

    frame_wr_if.producer         wr
);

    frame_u asm_q;
    logic   wr_accept;
    logic   datar_push;

    // Writes are taken only while no push is in flight
    assign wr_accept = i_av_slave_sel && i_av_write && !wr.req && !wr.ack;

    // Upper right lane completes the frame
    assign datar_push = wr_accept && (i_av_reg_addr == REG_DATAR)
                        && i_av_byte_en[SAMPLE_BYTES-1];

    assign wr.frame = asm_q;

    // Frame assembly and push handshake
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            asm_q             <= '0;
            wr.req            <= 1'b0;
            o_av_wait_request <= 1'b0;
        end else begin
            if (wr_accept && (i_av_reg_addr == REG_DATAL)) begin
                for (int k = 0; k < SAMPLE_BYTES; k++) begin
                    if (i_av_byte_en[k]) begin
                        asm_q.stereo.left[8*k +: 8] <= i_av_write_data[8*k +: 8];
                    end
                end
            end

            if (wr_accept && (i_av_reg_addr == REG_DATAR)) begin
                for (int k = 0; k < SAMPLE_BYTES; k++) begin
                    if (i_av_byte_en[k]) begin
                        asm_q.stereo.right[8*k +: 8] <= i_av_write_data[8*k +: 8];
                    end
                end
            end

            if (datar_push) begin
                wr.req            <= 1'b1;
                o_av_wait_request <= 1'b1;
            end else if (wr.req && wr.ack) begin
                // Frame is stored, release bus and req
                wr.req            <= 1'b0;
                o_av_wait_request <= 1'b0;
            end
        end
    end

    // Register reads, one cycle latency
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            o_av_read_data <= '0;
        end else if (i_av_slave_sel && i_av_read) begin
            case (i_av_reg_addr)
                REG_CNTRL: begin
                    o_av_read_data <= {{(AV_DATA_W-1){1'b0}}, wr.full};
                end
                REG_DATAL: begin
                    o_av_read_data <= AV_DATA_W'(asm_q.stereo.left);
                end
                REG_DATAR: begin
                    o_av_read_data <= AV_DATA_W'(asm_q.stereo.right);
                end
                default: begin
                    o_av_read_data <= '0;
                end
            endcase
        end else begin
            o_av_read_data <= '0;
        end
    end

endmodule

//--- frame_if.sv
`timescale 1ns/10ps

// Front end to FIFO push link
interface frame_wr_if import i2s_audio_pkg::*; ();

    logic   req;
    logic   ack;
    logic   full;
    frame_u frame;

    modport producer (
        output req, frame,
        input  ack, full
    );

    modport buffer (
        input  req, frame,
        output ack, full
    );

endinterface

// FIFO to serializer pull link
interface frame_rd_if import i2s_audio_pkg::*; ();

    logic   req;
    logic   ack;
    logic   underrun;
    frame_u frame;

    modport buffer (
        input  req,
        output ack, frame, underrun
    );

    modport consumer (
        output req,
        input  ack, frame, underrun
    );

endinterface

//--- i2s_audio_pkg.sv
package i2s_audio_pkg;

    // Sample and frame geometry
    localparam int SAMPLE_W     = 24;
    localparam int SAMPLE_BYTES = SAMPLE_W / 8;
    localparam int FRAME_W      = 2 * SAMPLE_W;
    localparam int BIT_CNT_W    = $clog2(FRAME_W);

    // Frame buffer
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // I2S clock dividers, in i_Audio_Clk cycles per period
    localparam int SCLK_DIV  = 4;
    localparam int SCLK_HALF = SCLK_DIV / 2;
    localparam int DIV_CNT_W = $clog2(SCLK_DIV);
    localparam int MCLK_DIV  = 2;
    localparam int MCLK_HALF = MCLK_DIV / 2;

    // Right sample sits in the upper half
    typedef struct packed {
        logic [SAMPLE_W-1:0] right;
        logic [SAMPLE_W-1:0] left;
    } stereo_s;

    typedef union packed {
        stereo_s             stereo;
        logic [FRAME_W-1:0]  raw;
    } frame_u;

endpackage

//--- i2s_bus_pkg.sv
package i2s_bus_pkg;

    // Avalon register port
    localparam int AV_ADDR_W = 4;
    localparam int AV_DATA_W = 32;
    localparam int AV_BE_W   = AV_DATA_W / 8;

    // Register map
    localparam logic [AV_ADDR_W-1:0] REG_CNTRL = 4'd0;
    localparam logic [AV_ADDR_W-1:0] REG_DATAL = 4'd1;
    localparam logic [AV_ADDR_W-1:0] REG_DATAR = 4'd2;

endpackage
